//--- include/Execute_consts.svh
`ifndef EXECUTE_CONSTS_SVH
`define EXECUTE_CONSTS_SVH

// Datapath and register file widths.
`define XLEN 32
`define REG_ADDR_WIDTH 5

// Single-bit control levels.
`define ENABLE 1'b1
`define DISABLE 1'b0

// Distance from a jump to its return address.
`define LINK_OFFSET 4

`endif

//--- design/PipelineTypes.sv
`include "Execute_consts.svh"

package PipelineTypes;

  // ====================
  // Basic words
  // ====================

  typedef logic [`XLEN-1:0] BasicData;
  typedef logic [`REG_ADDR_WIDTH-1:0] RegAddr;

  // ====================
  // Operation decoding
  // ====================

  typedef enum logic [3:0] {
    OP_REG,
    OP_IMM,
    OP_LUI,
    OP_AUIPC,
    OP_JAL,
    OP_JALR,
    OP_BRANCH,
    OP_LOAD,
    OP_STORE
  } OpType;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND
  } AluCode;

  typedef enum logic [3:0] {
    MUL,
    MULH,
    MULHSU,
    MULHU,
    DIV,
    DIVU,
    REM,
    REMU
  } MulDivCode;

  // The same function field is read by the ALU or by the multiply/divide unit,
  // depending on isMulDiv.
  typedef union packed {
    AluCode aluCode;
    MulDivCode mulDivCode;
  } ExecCode;

  typedef enum logic [2:0] {
    BEQ,
    BNE,
    BLT,
    BGE,
    BLTU,
    BGEU
  } BranchCode;

  typedef enum logic [1:0] {
    BYPASS_NONE,
    BYPASS_EXEC,
    BYPASS_MEM
  } BypassCtrl;

  typedef enum logic [1:0] {
    MEM_BYTE,
    MEM_HALF,
    MEM_WORD
  } MemAccessWidth;

endpackage

//--- design/OperandSwitcher.sv
`timescale 1ns/1ns
`include "Execute_consts.svh"

module OperandSwitcher (
  input  PipelineTypes::BasicData pc,
  input  PipelineTypes::BasicData rs1,
  input  PipelineTypes::BasicData rs2,
  input  PipelineTypes::BasicData imm,
  input  PipelineTypes::OpType    opType,
  output PipelineTypes::BasicData aluOp1,
  output PipelineTypes::BasicData aluOp2,
  output PipelineTypes::BasicData npcOp1,
  output PipelineTypes::BasicData npcOp2
);

  import PipelineTypes::*;

  // ALU operands by operation type.
  always_comb begin
    case (opType)
      OP_IMM, OP_LOAD, OP_STORE: begin
        aluOp1 = rs1;
        aluOp2 = imm;
      end
      OP_LUI: begin
        aluOp1 = '0;
        aluOp2 = imm;
      end
      OP_AUIPC: begin
        aluOp1 = pc;
        aluOp2 = imm;
      end
      OP_JAL, OP_JALR: begin
        aluOp1 = pc;
        aluOp2 = `XLEN'(`LINK_OFFSET);
      end
      default: begin
        aluOp1 = rs1;
        aluOp2 = rs2;
      end
    endcase
  end

  // Only JALR jumps relative to a register, everything else is PC relative.
  assign npcOp1 = (opType == OP_JALR) ? rs1 : pc;
  assign npcOp2 = imm;

endmodule

//--- design/IntAlu.sv
`timescale 1ns/1ns
`include "Execute_consts.svh"

module IntAlu (
  input  PipelineTypes::AluCode   aluCode,
  input  PipelineTypes::BasicData op1,
  input  PipelineTypes::BasicData op2,
  output PipelineTypes::BasicData aluResult
);

  import PipelineTypes::*;

  logic [$clog2(`XLEN)-1:0] shamt;
  logic lessSigned;
  logic lessUnsigned;

  assign shamt = op2[$clog2(`XLEN)-1:0];
  assign lessSigned = ($signed(op1) < $signed(op2));
  assign lessUnsigned = (op1 < op2);

  always_comb begin
    case (aluCode)
      ADD:  aluResult = op1 + op2;
      SUB:  aluResult = op1 - op2;
      SLL:  aluResult = op1 << shamt;
      SLT:  aluResult = {{(`XLEN-1){1'b0}}, lessSigned};
      SLTU: aluResult = {{(`XLEN-1){1'b0}}, lessUnsigned};
      XOR:  aluResult = op1 ^ op2;
      SRL:  aluResult = op1 >> shamt;
      SRA:  aluResult = BasicData'($signed(op1) >>> shamt);
      OR:   aluResult = op1 | op2;
      AND:  aluResult = op1 & op2;
      default: begin
        aluResult = '0;
      end
    endcase
  end

endmodule

//--- design/MulDivUnit.sv
`timescale 1ns/1ns
`include "Execute_consts.svh"

module MulDivUnit (
  input  PipelineTypes::MulDivCode mulDivCode,
  input  PipelineTypes::BasicData  op1,
  input  PipelineTypes::BasicData  op2,
  output PipelineTypes::BasicData  result
);

  import PipelineTypes::*;

  logic op1Signed;
  logic op2Signed;
  logic signed [`XLEN:0] op1Ext;
  logic signed [`XLEN:0] op2Ext;
  logic signed [2*`XLEN+1:0] product;
  logic divByZero;
  logic divOverflow;
  BasicData safeDivisor;
  BasicData quotSigned;
  BasicData quotUnsigned;
  BasicData remSigned;
  BasicData remUnsigned;

  // ====================
  // Multiply
  // ====================

  // One extra bit per operand lets a single signed multiplier cover all three
  // high-half variants.
  always_comb begin
    case (mulDivCode)
      MULH: begin
        op1Signed = 1'b1;
        op2Signed = 1'b1;
      end
      MULHSU: begin
        op1Signed = 1'b1;
        op2Signed = 1'b0;
      end
      default: begin
        op1Signed = 1'b0;
        op2Signed = 1'b0;
      end
    endcase
  end

  assign op1Ext = {op1Signed & op1[`XLEN-1], op1};
  assign op2Ext = {op2Signed & op2[`XLEN-1], op2};
  assign product = op1Ext * op2Ext;

  // ====================
  // Divide
  // ====================

  assign divByZero = (op2 == '0);
  assign divOverflow = (op1 == {1'b1, {(`XLEN-1){1'b0}}}) && (op2 == '1);
  assign safeDivisor = divByZero ? `XLEN'(1) : op2;

  assign quotSigned = BasicData'($signed(op1) / $signed(safeDivisor));
  assign remSigned = BasicData'($signed(op1) % $signed(safeDivisor));
  assign quotUnsigned = op1 / safeDivisor;
  assign remUnsigned = op1 % safeDivisor;

  always_comb begin
    case (mulDivCode)
      MUL:                 result = product[`XLEN-1:0];
      MULH, MULHSU, MULHU: result = product[2*`XLEN-1:`XLEN];
      DIV:  result = divByZero ? '1 : (divOverflow ? op1 : quotSigned);
      DIVU: result = divByZero ? '1 : quotUnsigned;
      REM:  result = divByZero ? op1 : (divOverflow ? '0 : remSigned);
      REMU: result = divByZero ? op1 : remUnsigned;
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- design/BranchResolver.sv
`timescale 1ns/1ns
`include "Execute_consts.svh"

module BranchResolver (
  input  PipelineTypes::BasicData  pc,
  input  PipelineTypes::OpType     opType,
  input  PipelineTypes::BranchCode brCode,
  input  PipelineTypes::BasicData  rs1Data,
  input  PipelineTypes::BasicData  rs2Data,
  input  PipelineTypes::BasicData  npcOp1,
  input  PipelineTypes::BasicData  npcOp2,
  output PipelineTypes::BasicData  irregPc,
  output logic                     isBranchTaken
);

  import PipelineTypes::*;

  logic condHolds;
  BasicData targetSum;
  BasicData target;

  always_comb begin
    case (brCode)
      BEQ:  condHolds = (rs1Data == rs2Data);
      BNE:  condHolds = (rs1Data != rs2Data);
      BLT:  condHolds = ($signed(rs1Data) < $signed(rs2Data));
      BGE:  condHolds = ($signed(rs1Data) >= $signed(rs2Data));
      BLTU: condHolds = (rs1Data < rs2Data);
      BGEU: condHolds = (rs1Data >= rs2Data);
      default: begin
        condHolds = `DISABLE;
      end
    endcase
  end

  always_comb begin
    case (opType)
      OP_JAL, OP_JALR: isBranchTaken = `ENABLE;
      OP_BRANCH:       isBranchTaken = condHolds;
      default: begin
        isBranchTaken = `DISABLE;
      end
    endcase
  end

  // JALR targets are forced to an even address.
  assign targetSum = npcOp1 + npcOp2;
  assign target = (opType == OP_JALR) ? {targetSum[`XLEN-1:1], 1'b0} : targetSum;

  assign irregPc = target;

endmodule

//--- design/ExecuteStage.sv
`timescale 1ns/1ns
`include "Execute_consts.svh"

module ExecuteStage (
  input  logic                          clk,
  input  logic                          reset,

  // Decode side.
  input  logic                          inValid,
  output logic                          inReady,
  input  PipelineTypes::BasicData       pc,
  input  PipelineTypes::BasicData       imm,
  input  PipelineTypes::BasicData       rs1Data,
  input  PipelineTypes::BasicData       rs2Data,
  input  PipelineTypes::BypassCtrl      op1Bypass,
  input  PipelineTypes::BypassCtrl      op2Bypass,
  input  PipelineTypes::OpType          opType,
  input  PipelineTypes::ExecCode        execCode,
  input  logic                          isMulDiv,
  input  PipelineTypes::BranchCode      brCode,
  input  logic                          isLoad,
  input  logic                          isStore,
  input  logic                          isLoadUnsigned,
  input  PipelineTypes::MemAccessWidth  memAccessWidth,
  input  logic                          wEnable,
  input  PipelineTypes::RegAddr         rdAddr,
  input  PipelineTypes::BasicData       predictedNextPc,

  // Bypass network.
  input  PipelineTypes::BasicData       bypassExData,
  input  PipelineTypes::BasicData       bypassMemData,

  // Memory side.
  output logic                          outValid,
  input  logic                          outReady,
  output PipelineTypes::BasicData       outPc,
  output PipelineTypes::BasicData       result,
  output PipelineTypes::BasicData       wData,
  output PipelineTypes::MemAccessWidth  outMemAccessWidth,
  output logic                          outIsLoad,
  output logic                          outIsStore,
  output logic                          outIsLoadUnsigned,
  output logic                          outWEnable,
  output PipelineTypes::RegAddr         outRdAddr,

  // Fetch redirect.
  output logic                          redirect,
  output PipelineTypes::BasicData       redirectPc
);

  import PipelineTypes::*;

  BasicData bypassedRs1;
  BasicData bypassedRs2;
  BasicData aluOp1;
  BasicData aluOp2;
  BasicData npcOp1;
  BasicData npcOp2;
  BasicData aluResult;
  BasicData mulDivResult;
  BasicData execResult;
  BasicData irregPc;
  BasicData actualNextPc;
  AluCode aluCode;
  logic useMulDiv;
  logic brTaken;
  logic accept;

  function automatic BasicData selectBypass(input BypassCtrl ctrl, input BasicData regData,
                                            input BasicData exData, input BasicData memData);
    BasicData sel;
    case (ctrl)
      BYPASS_EXEC: sel = exData;
      BYPASS_MEM:  sel = memData;
      default: begin
        sel = regData;
      end
    endcase
    return sel;
  endfunction

  // ====================
  // Operand resolution
  // ====================

  assign bypassedRs1 = selectBypass(op1Bypass, rs1Data, bypassExData, bypassMemData);
  assign bypassedRs2 = selectBypass(op2Bypass, rs2Data, bypassExData, bypassMemData);

  OperandSwitcher operandSwitcher0 (
    .pc(pc),
    .rs1(bypassedRs1),
    .rs2(bypassedRs2),
    .imm(imm),
    .opType(opType),
    .aluOp1(aluOp1),
    .aluOp2(aluOp2),
    .npcOp1(npcOp1),
    .npcOp2(npcOp2)
  );

  // ====================
  // Compute
  // ====================

  // Address, link and upper-immediate forms all reduce to an add.
  always_comb begin
    if (opType == OP_REG || opType == OP_IMM) begin
      aluCode = execCode.aluCode;
    end else begin
      aluCode = ADD;
    end
  end

  assign useMulDiv = isMulDiv && (opType == OP_REG);

  IntAlu intAlu0 (
    .aluCode(aluCode),
    .op1(aluOp1),
    .op2(aluOp2),
    .aluResult(aluResult)
  );

  MulDivUnit mulDivUnit0 (
    .mulDivCode(execCode.mulDivCode),
    .op1(aluOp1),
    .op2(aluOp2),
    .result(mulDivResult)
  );

  assign execResult = useMulDiv ? mulDivResult : aluResult;

  BranchResolver branchResolver0 (
    .pc(pc),
    .opType(opType),
    .brCode(brCode),
    .rs1Data(bypassedRs1),
    .rs2Data(bypassedRs2),
    .npcOp1(npcOp1),
    .npcOp2(npcOp2),
    .irregPc(irregPc),
    .isBranchTaken(brTaken)
  );

  // ====================
  // Redirect and handshake
  // ====================

  assign actualNextPc = brTaken ? irregPc : pc + `XLEN'(`LINK_OFFSET);

  assign inReady = !outValid || outReady;
  assign accept = inValid && inReady;

  // The redirect is only meaningful in the cycle the operation is taken in.
  assign redirect = accept && (actualNextPc != predictedNextPc);
  assign redirectPc = accept ? actualNextPc : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      outValid <= `DISABLE;
      outPc <= '0;
      result <= '0;
      wData <= '0;
      outMemAccessWidth <= MEM_BYTE;
      outIsLoad <= `DISABLE;
      outIsStore <= `DISABLE;
      outIsLoadUnsigned <= `DISABLE;
      outWEnable <= `DISABLE;
      outRdAddr <= '0;
    end else if (accept) begin
      outValid <= `ENABLE;
      outPc <= pc;
      result <= execResult;
      wData <= bypassedRs2;
      outMemAccessWidth <= memAccessWidth;
      outIsLoad <= isLoad;
      outIsStore <= isStore;
      outIsLoadUnsigned <= isLoadUnsigned;
      outWEnable <= wEnable;
      outRdAddr <= rdAddr;
    end else if (outReady) begin
      outValid <= `DISABLE;
    end
  end

endmodule

//--- tests/ExecuteStageTb.sv
`timescale 1ns/1ns
`include "Execute_consts.svh"

module ExecuteStageTb;

  import PipelineTypes::*;

  localparam int HalfPeriod = 10;
  localparam int ClkPeriod = 2 * HalfPeriod;
  // Operations issued by all tests together.
  localparam int OpCount = 89;
  localparam BasicData SignBit = {1'b1, {(`XLEN-1){1'b0}}};

  logic clk, reset, inValid, inReady, isMulDiv, isLoad, isStore, isLoadUnsigned, wEnable;
  logic outValid, outReady, outIsLoad, outIsStore, outIsLoadUnsigned, outWEnable, redirect;
  BasicData pc, imm, rs1Data, rs2Data, predictedNextPc, bypassExData, bypassMemData;
  BasicData outPc, result, wData, redirectPc;
  BypassCtrl op1Bypass, op2Bypass;
  OpType opType;
  ExecCode execCode;
  BranchCode brCode;
  MemAccessWidth memAccessWidth, outMemAccessWidth;
  RegAddr rdAddr, outRdAddr;

  logic [31:0] lfsrState;
  logic stallMode;
  BasicData pcCursor;
  int checks;
  int errors;
  BasicData expResult[$];
  logic expResultOn[$];
  BasicData expWData[$];
  BasicData expPc[$];
  logic [10:0] expMem[$];

  ExecuteStage dut0 (.*);

  always #HalfPeriod clk = ~clk;

  // ====================
  // Random source and reference models
  // ====================

  function automatic logic [31:0] lfsrStep(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic BasicData randomBits(int n);
    BasicData w;
    w = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrStep(lfsrState);
      w[i] = lfsrState[0];
    end
    return w;
  endfunction

  function automatic BasicData aluModel(AluCode c, BasicData a, BasicData b);
    logic [63:0] ext;
    ext = {{32{a[31]}}, a} >> b[4:0];
    case (c)
      ADD:  return a + b;
      SUB:  return a - b;
      SLL:  return a << b[4:0];
      SLT:  return BasicData'($signed(a) < $signed(b));
      SLTU: return BasicData'(a < b);
      XOR:  return a ^ b;
      SRL:  return a >> b[4:0];
      SRA:  return ext[31:0];
      OR:   return a | b;
      AND:  return a & b;
      default: return '0;
    endcase
  endfunction

  function automatic BasicData mulDivModel(MulDivCode c, BasicData a, BasicData b);
    longint sa;
    longint sb;
    longint ub;
    logic [63:0] prod;
    logic overflow;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    ub = longint'({32'b0, b});
    overflow = (a == SignBit) && (b == '1);
    case (c)
      MULHSU: prod = sa * ub;
      MULHU:  prod = longint'({32'b0, a}) * ub;
      default: prod = sa * sb;
    endcase
    case (c)
      MUL:  return prod[31:0];
      DIV:  return (b == '0) ? '1 : (overflow ? a : BasicData'(int'(a) / int'(b)));
      DIVU: return (b == '0) ? '1 : a / b;
      REM:  return (b == '0) ? a : (overflow ? '0 : BasicData'(int'(a) % int'(b)));
      REMU: return (b == '0) ? a : a % b;
      default: return prod[63:32];
    endcase
  endfunction

  function automatic logic branchModel(BranchCode c, BasicData a, BasicData b);
    case (c)
      BEQ:  return a == b;
      BNE:  return a != b;
      BLT:  return $signed(a) < $signed(b);
      BGE:  return !($signed(a) < $signed(b));
      BLTU: return a < b;
      default: return !(a < b);
    endcase
  endfunction

  // ====================
  // Checks
  // ====================

  task automatic checkData(BasicData got, BasicData exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkRedirect(logic got, BasicData gotPc, logic exp, BasicData expPc);
    checks++;
    if (got !== exp || gotPc !== expPc) begin
      errors++;
      $display("error %0t: redirect got %b/%h expected %b/%h", $time, got, gotPc, exp, expPc);
    end
  endtask

  task automatic checkMemCtrl(MemAccessWidth gotWidth, MemAccessWidth expWidth,
                              logic [3:0] gotFlags, logic [3:0] expFlags,
                              RegAddr gotRd, RegAddr expRd);
    checks++;
    if (gotWidth !== expWidth || gotFlags !== expFlags || gotRd !== expRd) begin
      errors++;
      $display("error %0t: memory controls got %0d/%b/%0d expected %0d/%b/%0d", $time,
               gotWidth, gotFlags, gotRd, expWidth, expFlags, expRd);
    end
  endtask

  task automatic expectTrue(logic cond, string what);
    checks++;
    if (!cond) begin
      errors++;
      $display("%s at time %0t", what, $time);
    end
  endtask

  // Plays the memory stage. Samples the handshake at the edge and checks at the falling edge.
  task automatic watchOutputs();
    logic accepted;
    logic held;
    BasicData acceptedPc, heldResult, heldPc, expRes;
    logic [10:0] mem;
    held = 1'b0;
    forever begin
      @(posedge clk);
      accepted = !reset && inValid && inReady;
      acceptedPc = pc;
      @(negedge clk);
      if (accepted) begin
        expectTrue(outValid, "An accepted operation did not reach the output one cycle later");
        checkData(outPc, acceptedPc, "pc one cycle after acceptance");
      end
      if (held) begin
        checkData(result, heldResult, "result under back-pressure");
        checkData(outPc, heldPc, "pc under back-pressure");
      end
      held = outValid && !outReady;
      heldResult = result;
      heldPc = outPc;
      if (held) begin
        expectTrue(!inReady, "inReady stayed high while the output was stalled");
      end
      if (outValid && outReady) begin
        expectTrue(expPc.size() != 0, "An output appeared with no operation outstanding");
        if (expPc.size() != 0) begin
          mem = expMem.pop_front();
          expRes = expResult.pop_front();
          checkData(outPc, expPc.pop_front(), "pc");
          if (expResultOn.pop_front()) begin
            checkData(result, expRes, "result");
          end
          checkData(wData, expWData.pop_front(), "wData");
          checkMemCtrl(outMemAccessWidth, MemAccessWidth'(mem[10:9]),
                       {outIsLoad, outIsStore, outIsLoadUnsigned, outWEnable}, mem[8:5],
                       outRdAddr, mem[4:0]);
        end
      end
    end
  endtask

  task automatic driveOutReady();
    logic [31:0] state;
    state = 32'h995b;
    forever begin
      @(posedge clk);
      if (stallMode) begin
        state = lfsrStep(state);
        outReady <= state[0];
      end else begin
        outReady <= 1'b1;
      end
    end
  endtask

  // ====================
  // Stimulus
  // ====================

  // Called on a rising edge. Places a and b on the sources named by s1 and s2, junk elsewhere.
  task automatic issue(OpType op, logic [3:0] code, logic md, BranchCode bc, BasicData immV,
                       BasicData a, BasicData b, BypassCtrl s1, BypassCtrl s2,
                       BasicData predicted, BasicData expRes, BasicData expNpc);
    BasicData junk;
    MemAccessWidth width;
    logic [3:0] flags;
    RegAddr rd;
    junk = randomBits(32);
    width = MemAccessWidth'(randomBits(2) % 3);
    flags = 4'(randomBits(4));
    rd = RegAddr'(randomBits(5));
    inValid <= 1'b1;
    pc <= pcCursor;
    imm <= immV;
    opType <= op;
    execCode <= code;
    isMulDiv <= md;
    brCode <= bc;
    op1Bypass <= s1;
    op2Bypass <= s2;
    rs1Data <= (s1 == BYPASS_NONE) ? a : junk;
    rs2Data <= (s2 == BYPASS_NONE) ? b : ~junk;
    bypassExData <= (s1 == BYPASS_EXEC) ? a : ((s2 == BYPASS_EXEC) ? b : junk + 1);
    bypassMemData <= (s1 == BYPASS_MEM) ? a : ((s2 == BYPASS_MEM) ? b : junk - 1);
    predictedNextPc <= predicted;
    memAccessWidth <= width;
    {isLoad, isStore, isLoadUnsigned, wEnable} <= flags;
    rdAddr <= rd;
    expPc.push_back(pcCursor);
    expResult.push_back(expRes);
    expResultOn.push_back(op != OP_BRANCH);
    expWData.push_back(b);
    expMem.push_back({width, flags, rd});
    pcCursor = pcCursor + `LINK_OFFSET;
    @(negedge clk);
    while (!inReady) begin
      checkRedirect(redirect, redirectPc, 1'b0, '0);
      @(negedge clk);
    end
    checkRedirect(redirect, redirectPc, expNpc != predicted, expNpc);
    @(posedge clk);
  endtask

  task automatic issueSeq(OpType op, logic [3:0] code, logic md, BasicData immV, BasicData a,
                          BasicData b, BypassCtrl s1, BypassCtrl s2, BasicData expRes);
    issue(op, code, md, BEQ, immV, a, b, s1, s2, pcCursor + `LINK_OFFSET, expRes,
          pcCursor + `LINK_OFFSET);
  endtask

  task automatic finishTest(string name);
    inValid <= 1'b0;
    while (expPc.size() != 0) begin
      @(posedge clk);
    end
    $display("%s finished, %0d errors so far", name, errors);
  endtask

  // ====================
  // Tests
  // ====================

  task automatic aluTest();
    BasicData a, b, immV;
    for (int c = 0; c < 10; c++) begin
      a = randomBits(32);
      b = randomBits(32);
      immV = randomBits(32);
      issueSeq(OP_REG, 4'(c), 1'b0, immV, a, b, BYPASS_NONE, BYPASS_NONE,
               aluModel(AluCode'(c), a, b));
      issueSeq(OP_IMM, 4'(c), 1'b0, immV, a, b, BYPASS_NONE, BYPASS_NONE,
               aluModel(AluCode'(c), a, immV));
    end
    immV = randomBits(32) & 32'hffff_f000;
    issueSeq(OP_LUI, ADD, 1'b0, immV, a, b, BYPASS_NONE, BYPASS_NONE, immV);
    issueSeq(OP_AUIPC, ADD, 1'b0, immV, a, b, BYPASS_NONE, BYPASS_NONE, pcCursor + immV);
    finishTest("aluTest");
  endtask

  task automatic mulDivTest();
    BasicData a, b;
    for (int c = 0; c < 8; c++) begin
      a = randomBits(32);
      b = randomBits(32);
      issueSeq(OP_REG, 4'(c), 1'b1, '0, a, b, BYPASS_NONE, BYPASS_NONE,
               mulDivModel(MulDivCode'(c), a, b));
    end
    // Division by zero, then the signed overflow case.
    for (int c = DIV; c <= REMU; c++) begin
      a = randomBits(32);
      issueSeq(OP_REG, 4'(c), 1'b1, '0, a, '0, BYPASS_NONE, BYPASS_NONE, (c == DIV ||
               c == DIVU) ? '1 : a);
    end
    issueSeq(OP_REG, DIV, 1'b1, '0, SignBit, '1, BYPASS_NONE, BYPASS_NONE, SignBit);
    issueSeq(OP_REG, REM, 1'b1, '0, SignBit, '1, BYPASS_NONE, BYPASS_NONE, '0);
    finishTest("mulDivTest");
  endtask

  task automatic bypassTest();
    BasicData a, b;
    for (int s1 = 0; s1 < 3; s1++) begin
      for (int s2 = 0; s2 < 3; s2++) begin
        if (s1 != s2 || s1 == 0) begin
          a = randomBits(32);
          b = randomBits(32);
          issueSeq(OP_REG, SUB, 1'b0, '0, a, b, BypassCtrl'(s1), BypassCtrl'(s2), a - b);
        end
      end
    end
    finishTest("bypassTest");
  endtask

  task automatic branchTest();
    BasicData a, b, immV, neg, pos, target;
    OpType op;
    for (int c = 0; c < 6; c++) begin
      for (int k = 0; k < 3; k++) begin
        neg = randomBits(32) | SignBit;
        pos = randomBits(32) & ~SignBit;
        a = (k == 2) ? pos : neg;
        b = (k == 0) ? neg : ((k == 1) ? pos : neg);
        immV = randomBits(12) << 1;
        target = branchModel(BranchCode'(c), a, b) ? pcCursor + immV : pcCursor + `LINK_OFFSET;
        issue(OP_BRANCH, ADD, 1'b0, BranchCode'(c), immV, a, b, BYPASS_NONE, BYPASS_NONE,
              pcCursor + `LINK_OFFSET, '0, target);
      end
    end
    // Each jump once with a correct and once with a wrong prediction.
    for (int j = 0; j < 4; j++) begin
      op = (j < 2) ? OP_JAL : OP_JALR;
      a = randomBits(32);
      b = randomBits(32);
      immV = randomBits(12) << 1;
      target = (op == OP_JAL) ? pcCursor + immV : (a + immV) & ~BasicData'(1);
      issue(op, ADD, 1'b0, BEQ, immV, a, b, BYPASS_NONE, BYPASS_NONE,
            j[0] ? target : target + 8, pcCursor + `LINK_OFFSET, target);
    end
    finishTest("branchTest");
  endtask

  task automatic memTest();
    BasicData a, b, immV;
    for (int j = 0; j < 4; j++) begin
      a = randomBits(32);
      b = randomBits(32);
      immV = randomBits(12);
      issueSeq(j[0] ? OP_STORE : OP_LOAD, ADD, 1'b0, immV, a, b, BYPASS_EXEC,
               (j < 2) ? BYPASS_NONE : BYPASS_MEM, a + immV);
    end
    finishTest("memTest");
  endtask

  task automatic backPressureTest();
    BasicData a, b;
    AluCode c;
    stallMode <= 1'b1;
    for (int n = 0; n < 20; n++) begin
      a = randomBits(32);
      b = randomBits(32);
      c = AluCode'(randomBits(4) % 10);
      issueSeq(OP_REG, c, 1'b0, '0, a, b, BYPASS_NONE, BYPASS_NONE, aluModel(c, a, b));
    end
    finishTest("backPressureTest");
    stallMode <= 1'b0;
  endtask

  initial begin
    #(OpCount * 40 * ClkPeriod);
    $display("Watchdog expired: the tests did not finish within %0d cycles", OpCount * 40);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    inValid = 1'b0;
    pc = '0;
    imm = '0;
    rs1Data = '0;
    rs2Data = '0;
    op1Bypass = BYPASS_NONE;
    op2Bypass = BYPASS_NONE;
    opType = OP_REG;
    execCode = '0;
    isMulDiv = 1'b0;
    brCode = BEQ;
    isLoad = 1'b0;
    isStore = 1'b0;
    isLoadUnsigned = 1'b0;
    memAccessWidth = MEM_BYTE;
    wEnable = 1'b0;
    rdAddr = '0;
    predictedNextPc = '0;
    bypassExData = '0;
    bypassMemData = '0;
    outReady = 1'b1;
    lfsrState = 32'h995b;
    stallMode = 1'b0;
    pcCursor = 32'h0000_1000;
    checks = 0;
    errors = 0;
    fork
      watchOutputs();
      driveOutReady();
    join_none
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    expectTrue(!outValid, "outValid was high right after reset");
    checkRedirect(redirect, redirectPc, 1'b0, '0);
    @(posedge clk);
    aluTest();
    mulDivTest();
    bypassTest();
    branchTest();
    memTest();
    backPressureTest();
    $display("Checks passed %0d, failed %0d", checks - errors, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+include
design/PipelineTypes.sv
design/OperandSwitcher.sv
design/IntAlu.sv
design/MulDivUnit.sv
design/BranchResolver.sv
design/ExecuteStage.sv
tests/ExecuteStageTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module ExecuteStageTb -f tb.f --Mdir obj_dir -o ExecuteStageSim \
  && ./obj_dir/ExecuteStageSim | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null \
  && echo "Simulation passed" \
  || { echo "Build or simulation failed"; exit 1; }
